// ==== logic/dp_pkg.sv ====
package dp_pkg;

  localparam int data_w = 32;
  localparam int addr_w = 5;
  localparam int op_w   = 6;
  localparam int sub_w  = 5;

  // major opcodes
  localparam logic [op_w-1:0] op_alu  = 6'h00;  // register form, see sub_opcode
  localparam logic [op_w-1:0] op_addi = 6'h08;
  localparam logic [op_w-1:0] op_ori  = 6'h0c;
  localparam logic [op_w-1:0] op_xori = 6'h0d;
  localparam logic [op_w-1:0] op_movi = 6'h10;

  // register form functions
  localparam logic [sub_w-1:0] sub_add   = 5'h00;
  localparam logic [sub_w-1:0] sub_sub   = 5'h01;
  localparam logic [sub_w-1:0] sub_and   = 5'h02;
  localparam logic [sub_w-1:0] sub_or    = 5'h03;
  localparam logic [sub_w-1:0] sub_xor   = 5'h04;
  localparam logic [sub_w-1:0] sub_slli  = 5'h08;
  localparam logic [sub_w-1:0] sub_srli  = 5'h09;
  localparam logic [sub_w-1:0] sub_rotri = 5'h0b;

  typedef enum logic [1:0] {
    imm5_ze  = 2'b00,
    imm15_se = 2'b01,
    imm15_ze = 2'b10,
    imm20_se = 2'b11
  } ext_sel_e;

  typedef struct packed {
    logic [4:0]  imm5;
    logic [14:0] imm15;
    logic [19:0] imm20;
  } imm_fields_t;

  typedef struct packed {
    logic [addr_w-1:0] rs1;
    logic [addr_w-1:0] rs2;
    logic [addr_w-1:0] rd;
    logic              fetch;
    logic              execute;
    logic              writeback;
    ext_sel_e          ext_sel;
    logic              use_imm;     // immediate as second operand
    logic              wb_move;     // write second operand instead of alu result
    logic [op_w-1:0]   opcode;
    logic [sub_w-1:0]  sub_opcode;
  } dp_ctrl_t;

endpackage

// ==== logic/regfile.sv ====
`timescale 1ns/1ps

module regfile #(
  parameter int data_w = dp_pkg::data_w,
  parameter int addr_w = dp_pkg::addr_w
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [addr_w-1:0] read_address1,
  input  logic [addr_w-1:0] read_address2,
  input  logic [addr_w-1:0] write_address,
  input  logic              read,
  input  logic              write,
  input  logic [data_w-1:0] write_data,
  output logic [data_w-1:0] read_data1,
  output logic [data_w-1:0] read_data2
);

  localparam int depth = 2 ** addr_w;

  logic [data_w-1:0] regs [depth];

  // read ports load on the fetch strobe and hold until the next one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_data1 <= '0;
      read_data2 <= '0;
    end else if (read) begin
      read_data1 <= regs[read_address1];  // old value if written this edge
      read_data2 <= regs[read_address2];
    end
  end

  // whole array cleared on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else if (write) begin
      regs[write_address] <= write_data;
    end
  end

  // a write to an unknown address would corrupt an unknown entry
  a_wr_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    write |-> !$isunknown(write_address)
  ) else $error("regfile write with unknown address");

endmodule

// ==== logic/imm_ext.sv ====
`timescale 1ns/1ps

module imm_ext (
  input  dp_pkg::imm_fields_t          imm,
  input  dp_pkg::ext_sel_e             ext_sel,
  output logic [dp_pkg::data_w-1:0]    imm_value
);

  import dp_pkg::*;

  localparam int w5  = $bits(imm.imm5);
  localparam int w15 = $bits(imm.imm15);
  localparam int w20 = $bits(imm.imm20);

  logic sign15;
  logic sign20;

  assign sign15 = imm.imm15[w15-1];
  assign sign20 = imm.imm20[w20-1];

  always_comb begin
    case (ext_sel)
      imm5_ze:  imm_value = {{(data_w-w5){1'b0}}, imm.imm5};
      imm15_se: imm_value = {{(data_w-w15){sign15}}, imm.imm15};
      imm15_ze: imm_value = {{(data_w-w15){1'b0}}, imm.imm15};
      imm20_se: imm_value = {{(data_w-w20){sign20}}, imm.imm20};
      default:  imm_value = '0;  // x on select
    endcase
  end

endmodule

// ==== logic/alu32.sv ====
`timescale 1ns/1ps

module alu32 #(
  parameter int data_w = dp_pkg::data_w
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     execute,
  input  logic [data_w-1:0]        src1,
  input  logic [data_w-1:0]        src2,
  input  logic [dp_pkg::op_w-1:0]  opcode,
  input  logic [dp_pkg::sub_w-1:0] sub_opcode,
  output logic [data_w-1:0]        alu_result,
  output logic                     alu_overflow
);

  import dp_pkg::*;

  localparam int sh_w = $clog2(data_w);
  localparam int msb  = data_w - 1;

  logic [sh_w-1:0]     shamt;
  logic [data_w-1:0]   sum;
  logic [data_w-1:0]   diff;
  logic [2*data_w-1:0] rot_wide;
  logic                add_ovf;
  logic                sub_ovf;
  logic [data_w-1:0]   result_d;
  logic                overflow_d;
  logic                no_ovf_op;

  assign shamt    = src2[sh_w-1:0];  // low bits only
  assign sum      = src1 + src2;
  assign diff     = src1 - src2;
  assign rot_wide = {src1, src1} >> shamt;

  // same signs in, different sign out
  assign add_ovf = (src1[msb] == src2[msb]) && (sum[msb] != src1[msb]);
  assign sub_ovf = (src1[msb] != src2[msb]) && (diff[msb] != src1[msb]);

  always_comb begin
    result_d   = '0;
    overflow_d = 1'b0;
    case (opcode)
      op_alu: begin
        case (sub_opcode)
          sub_add: begin
            result_d   = sum;
            overflow_d = add_ovf;
          end
          sub_sub: begin
            result_d   = diff;
            overflow_d = sub_ovf;
          end
          sub_and:   result_d = src1 & src2;
          sub_or:    result_d = src1 | src2;
          sub_xor:   result_d = src1 ^ src2;
          sub_slli:  result_d = src1 << shamt;
          sub_srli:  result_d = src1 >> shamt;
          sub_rotri: result_d = rot_wide[data_w-1:0];
          default:   result_d = '0;
        endcase
      end
      op_addi: begin
        result_d   = sum;
        overflow_d = add_ovf;
      end
      op_ori:  result_d = src1 | src2;
      op_xori: result_d = src1 ^ src2;
      op_movi: result_d = src2;
      default: result_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alu_result   <= '0;
      alu_overflow <= 1'b0;
    end else if (execute) begin
      alu_result   <= result_d;
      alu_overflow <= overflow_d;
    end
  end

  // logic and shift group, never overflows
  assign no_ovf_op = (opcode == op_ori) || (opcode == op_xori) ||
                     ((opcode == op_alu) &&
                      (sub_opcode inside {sub_and, sub_or, sub_xor,
                                          sub_slli, sub_srli, sub_rotri}));

  a_opcode_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    execute |-> !$isunknown(opcode)
  ) else $error("alu execute with unknown opcode");

  a_no_ovf_logic: assert property (
    @(posedge clk) disable iff (!rst_n)
    execute && no_ovf_op |=> !alu_overflow
  ) else $error("overflow set after logic or shift operation");

endmodule

// ==== logic/p3_top.sv ====
`timescale 1ns/1ps

module p3_top #(
  parameter int data_w = dp_pkg::data_w,
  parameter int addr_w = dp_pkg::addr_w
) (
  input  logic                clk,
  input  logic                rst_n,
  input  dp_pkg::dp_ctrl_t    ctrl,
  input  dp_pkg::imm_fields_t imm,
  output logic [data_w-1:0]   alu_result,
  output logic                alu_overflow
);

  logic [data_w-1:0] read_data1;
  logic [data_w-1:0] read_data2;
  logic [data_w-1:0] imm_value;
  logic [data_w-1:0] src2;
  logic [data_w-1:0] write_data;

  // operand mux
  assign src2 = ctrl.use_imm ? imm_value : read_data2;

  // writeback mux, move or alu result
  assign write_data = ctrl.wb_move ? src2 : alu_result;

  regfile #(
    .data_w(data_w),
    .addr_w(addr_w)
  ) i_regfile (
    .clk           (clk),
    .rst_n         (rst_n),
    .read_address1 (ctrl.rs1),
    .read_address2 (ctrl.rs2),
    .write_address (ctrl.rd),
    .read          (ctrl.fetch),
    .write         (ctrl.writeback),
    .write_data    (write_data),
    .read_data1    (read_data1),
    .read_data2    (read_data2)
  );

  imm_ext i_imm_ext (
    .imm       (imm),
    .ext_sel   (ctrl.ext_sel),
    .imm_value (imm_value)
  );

  alu32 #(
    .data_w(data_w)
  ) i_alu (
    .clk          (clk),
    .rst_n        (rst_n),
    .execute      (ctrl.execute),
    .src1         (read_data1),
    .src2         (src2),
    .opcode       (ctrl.opcode),
    .sub_opcode   (ctrl.sub_opcode),
    .alu_result   (alu_result),
    .alu_overflow (alu_overflow)
  );

endmodule

// ==== verif/p3_checker.sv ====
`timescale 1ns/1ps

module p3_checker #(
  parameter int data_w = dp_pkg::data_w
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              check,       // one cycle after execute
  input  int                test_idx,
  input  logic [data_w-1:0] exp_result,
  input  logic              exp_ovf,
  input  logic [data_w-1:0] alu_result,
  input  logic              alu_overflow,
  output int                pass_cnt,
  output int                fail_cnt
);

  int errors;

  initial begin
    pass_cnt = 0;
    fail_cnt = 0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      pass_cnt = 0;
      fail_cnt = 0;
    end else if (check) begin
      errors = 0;
      if (alu_result !== exp_result) begin
        $display("[FAIL] time %0t test %0d alu_result got %h expected %h",
                 $time, test_idx, alu_result, exp_result);
        errors++;
      end
      if (alu_overflow !== exp_ovf) begin
        $display("[FAIL] time %0t test %0d alu_overflow got %b expected %b",
                 $time, test_idx, alu_overflow, exp_ovf);
        errors++;
      end
      if (errors == 0) begin
        pass_cnt++;
        $display("[PASS] test %0d result %h overflow %b", test_idx, alu_result, alu_overflow);
      end else begin
        fail_cnt++;
      end
    end
  end

endmodule

// ==== verif/tb_p3_top.sv ====
`timescale 1ns/1ps

module tb_p3_top;

  import dp_pkg::*;

  localparam int n_cols   = 13;  // words per vector line
  localparam int max_recs = 64;

  typedef struct packed {
    dp_ctrl_t          ctrl;
    imm_fields_t       imm;
    logic [data_w-1:0] exp_result;
    logic              exp_ovf;
  } test_rec_t;

  logic              clk;
  logic              rst_n;
  dp_ctrl_t          ctrl;
  imm_fields_t       imm;
  logic [data_w-1:0] alu_result;
  logic              alu_overflow;

  logic              check;
  int                test_idx;
  logic [data_w-1:0] exp_result;
  logic              exp_ovf;
  int                pass_cnt;
  int                fail_cnt;

  logic [31:0] vec_mem [n_cols*max_recs];
  test_rec_t   recs [max_recs];
  int          n_recs;
  int          cycles = 0;
  int          cycle_limit = 20;

  p3_top #(
    .data_w(data_w),
    .addr_w(addr_w)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl         (ctrl),
    .imm          (imm),
    .alu_result   (alu_result),
    .alu_overflow (alu_overflow)
  );

  p3_checker #(
    .data_w(data_w)
  ) i_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .check        (check),
    .test_idx     (test_idx),
    .exp_result   (exp_result),
    .exp_ovf      (exp_ovf),
    .alu_result   (alu_result),
    .alu_overflow (alu_overflow),
    .pass_cnt     (pass_cnt),
    .fail_cnt     (fail_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic load_vectors();
    int base;
    $readmemh("verif/p3_vectors.txt", vec_mem);
    n_recs = 0;
    // unread words stay x, first x row ends the list
    while (n_recs < max_recs && !$isunknown(vec_mem[n_recs*n_cols])) begin
      base = n_recs * n_cols;
      recs[n_recs]                 = '0;
      recs[n_recs].ctrl.rs1        = vec_mem[base][addr_w-1:0];
      recs[n_recs].ctrl.rs2        = vec_mem[base+1][addr_w-1:0];
      recs[n_recs].ctrl.rd         = vec_mem[base+2][addr_w-1:0];
      recs[n_recs].ctrl.ext_sel    = ext_sel_e'(vec_mem[base+3][1:0]);
      recs[n_recs].ctrl.use_imm    = vec_mem[base+4][0];
      recs[n_recs].ctrl.wb_move    = vec_mem[base+5][0];
      recs[n_recs].ctrl.opcode     = vec_mem[base+6][op_w-1:0];
      recs[n_recs].ctrl.sub_opcode = vec_mem[base+7][sub_w-1:0];
      recs[n_recs].imm.imm5        = vec_mem[base+8][4:0];
      recs[n_recs].imm.imm15       = vec_mem[base+9][14:0];
      recs[n_recs].imm.imm20       = vec_mem[base+10][19:0];
      recs[n_recs].exp_result      = vec_mem[base+11][data_w-1:0];
      recs[n_recs].exp_ovf         = vec_mem[base+12][0];
      n_recs++;
    end
  endtask

  task automatic set_check(input int idx, input logic [data_w-1:0] res, input logic ovf);
    check      = 1'b1;
    test_idx   = idx;
    exp_result = res;
    exp_ovf    = ovf;
  endtask

  // fetch, execute, writeback, each followed by an idle cycle
  task automatic run_record(input int idx);
    @(negedge clk);
    ctrl       = recs[idx].ctrl;  // fields held for all six cycles
    imm        = recs[idx].imm;
    ctrl.fetch = 1'b1;
    @(negedge clk);
    ctrl.fetch = 1'b0;
    @(negedge clk);
    ctrl.execute = 1'b1;
    @(negedge clk);
    ctrl.execute = 1'b0;
    set_check(idx + 1, recs[idx].exp_result, recs[idx].exp_ovf);
    @(negedge clk);
    check          = 1'b0;
    ctrl.writeback = 1'b1;
    @(negedge clk);
    ctrl.writeback = 1'b0;
  endtask

  initial begin
    bit failed;
    rst_n      = 1'b0;
    ctrl       = '0;
    imm        = '0;
    check      = 1'b0;
    test_idx   = 0;
    exp_result = '0;
    exp_ovf    = 1'b0;
    load_vectors();
    cycle_limit = n_recs * 8 + 20;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    set_check(0, '0, 1'b0);  // outputs still at reset values
    @(negedge clk);
    check = 1'b0;
    for (int i = 0; i < n_recs; i++) begin
      run_record(i);
    end
    repeat (2) @(negedge clk);
    failed = (n_recs == 0) || (fail_cnt != 0) || (pass_cnt + fail_cnt != n_recs + 1);
    if (n_recs == 0) begin
      $display("no test vectors were read from the vector file");
    end
    if (pass_cnt + fail_cnt != n_recs + 1) begin
      $display("only %0d of %0d tests were checked", pass_cnt + fail_cnt, n_recs + 1);
    end
    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (failed) begin
      $display("TESTS FAILED");
    end else begin
      $display("TESTS PASSED");
    end
    $finish;
  end

endmodule

// ==== verif/p3_vectors.txt ====
// rs1 rs2 rd ext_sel use_imm wb_move opcode sub imm5 imm15 imm20 exp_result exp_ovf
// ext_sel 0 imm5_ze 1 imm15_se 2 imm15_ze 3 imm20_se, register 31 takes unused results
00 00 1f 0 0 0 00 00 00 0000 00000 00000000 0
00 00 1f 0 1 1 10 00 1f 0000 00000 0000001f 0
00 00 1f 1 1 1 10 00 00 4001 00000 ffffc001 0
00 00 1f 1 1 1 10 00 00 1234 00000 00001234 0
00 00 1f 2 1 1 10 00 00 7abc 00000 00007abc 0
00 00 1f 3 1 1 10 00 00 0000 80005 fff80005 0
00 00 1f 3 1 1 10 00 00 0000 7ffff 0007ffff 0
00 00 01 3 1 1 10 00 00 0000 12345 00012345 0
00 00 02 3 1 1 10 00 00 0000 f0f0f ffff0f0f 0
01 02 1f 0 0 0 00 00 00 0000 00000 00003254 0
01 02 1f 0 0 0 00 01 00 0000 00000 00021436 0
01 02 1f 0 0 0 00 02 00 0000 00000 00010305 0
01 02 1f 0 0 0 00 03 00 0000 00000 ffff2f4f 0
01 02 1f 0 0 0 00 04 00 0000 00000 fffe2c4a 0
00 00 03 3 1 1 10 00 00 0000 fffff ffffffff 0
03 00 04 0 1 0 00 09 01 0000 00000 7fffffff 0
04 00 05 1 1 0 08 00 00 0001 00000 80000000 1
04 00 1f 2 1 0 0c 00 00 0000 00000 7fffffff 0
05 01 1f 0 0 0 00 01 00 0000 00000 7ffedcbb 1
01 01 1f 0 0 0 00 04 00 0000 00000 00000000 0
05 03 1f 0 0 0 00 00 00 0000 00000 7fffffff 1
04 00 1f 2 1 0 0d 00 00 7fff 00000 7fff8000 0
01 00 1f 0 1 0 00 08 00 0000 00000 00012345 0
01 00 1f 0 1 0 00 08 01 0000 00000 0002468a 0
01 00 1f 0 1 0 00 08 1f 0000 00000 80000000 0
02 00 1f 0 1 0 00 09 00 0000 00000 ffff0f0f 0
02 00 1f 0 1 0 00 09 1f 0000 00000 00000001 0
01 00 1f 0 1 0 00 0b 00 0000 00000 00012345 0
01 00 1f 0 1 0 00 0b 01 0000 00000 800091a2 0
01 00 1f 0 1 0 00 0b 1f 0000 00000 0002468a 0
00 04 1f 0 0 1 10 00 00 0000 00000 7fffffff 0
00 05 1f 0 0 1 10 00 00 0000 00000 80000000 0

// ==== src.f ====
logic/dp_pkg.sv
logic/regfile.sv
logic/imm_ext.sv
logic/alu32.sv
logic/p3_top.sv
verif/p3_checker.sv
verif/tb_p3_top.sv

// ==== Bender.yml ====
package:
  name: p3_datapath

sources:
  - logic/dp_pkg.sv
  - logic/regfile.sv
  - logic/imm_ext.sv
  - logic/alu32.sv
  - logic/p3_top.sv
  - target: test
    files:
      - verif/p3_checker.sv
      - verif/tb_p3_top.sv
